/* hw/isp_pkg.sv */
`default_nettype none

package isp_pkg;

    // ========================================================================
    // bus and pixel widths
    // ========================================================================
    localparam int PIXEL_W = 8;
    localparam int LANES   = 16;
    localparam int DATA_W  = LANES * PIXEL_W;
    localparam int ADDR_W  = 32;

    // picture placement in DRAM
    localparam logic [ADDR_W-1:0] PIC_BASE   = 32'h0001_0000;
    localparam logic [ADDR_W-1:0] PIC_STRIDE = 32'd3072;

    typedef enum logic [1:0] {
        RATIO_QUARTER = 2'd0,
        RATIO_HALF    = 2'd1,
        RATIO_UNITY   = 2'd2,
        RATIO_DOUBLE  = 2'd3
    } ratio_e;

    typedef enum logic [1:0] {
        CH_RED   = 2'd0,
        CH_GREEN = 2'd1,
        CH_BLUE  = 2'd2
    } chan_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DOUT  = 2'd3
    } ctrl_state_e;

    // truncating exposure rule per pixel where doubling saturates at full scale
    function automatic logic [PIXEL_W-1:0] scale_pixel(input logic [PIXEL_W-1:0] pix,
                                                       input ratio_e ratio);
        logic [PIXEL_W-1:0] res;
        case (ratio)
            RATIO_QUARTER: res = pix >> 2;
            RATIO_HALF:    res = pix >> 1;
            RATIO_DOUBLE:  res = pix[PIXEL_W-1] ? '1 : {pix[PIXEL_W-2:0], 1'b0};
            default:       res = pix;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

/* hw/isp_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [3:0]                   in_pic_no,
    input  isp_pkg::ratio_e              in_ratio_mode,
    output isp_pkg::ratio_e              ratio,
    output logic [isp_pkg::ADDR_W-1:0]   araddr,
    output logic                         arvalid,
    input  logic                         arready,
    output logic [isp_pkg::ADDR_W-1:0]   awaddr,
    output logic                         awvalid,
    input  logic                         awready,
    input  logic                         rvalid,
    input  logic                         rlast,
    output logic                         rready,
    output logic                         beat_take,
    input  logic                         wb_space,
    input  logic                         wb_done,
    input  logic [isp_pkg::PIXEL_W-1:0]  mean_luma,
    input  logic                         mean_valid,
    output logic                         out_valid,
    output logic [isp_pkg::PIXEL_W-1:0]  out_data
);

    isp_pkg::ctrl_state_e        state;
    isp_pkg::ctrl_state_e        state_nxt;
    logic [isp_pkg::ADDR_W-1:0]  pic_addr;
    logic                        wb_seen;
    logic                        mean_seen;
    logic                        drain_done;
    logic [isp_pkg::PIXEL_W-1:0] mean_q;

    // ========================================================================
    // FSM
    // ========================================================================
    assign drain_done = (wb_seen | wb_done) & (mean_seen | mean_valid);

    always_comb begin
        state_nxt = state;
        case (state)
            isp_pkg::ST_IDLE: begin
                if (in_valid) begin
                    state_nxt = isp_pkg::ST_READ;
                end
            end
            isp_pkg::ST_READ: begin
                if (beat_take && rlast) begin
                    state_nxt = isp_pkg::ST_DRAIN;
                end
            end
            isp_pkg::ST_DRAIN: begin
                if (drain_done) begin
                    state_nxt = isp_pkg::ST_DOUT;
                end
            end
            default: state_nxt = isp_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= isp_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request capture with one address for read and write
    always_ff @(posedge clk) begin
        if (in_valid) begin
            pic_addr <= isp_pkg::PIC_BASE + in_pic_no * isp_pkg::PIC_STRIDE;
            ratio    <= in_ratio_mode;
        end
    end

    assign araddr = pic_addr;
    assign awaddr = pic_addr;

    // ========================================================================
    // address valids and read gating
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
        end else begin
            if (in_valid) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            if (in_valid) begin
                awvalid <= 1'b1;
            end else if (awready) begin
                awvalid <= 1'b0;
            end
        end
    end

    // stall the read stream while the write register is blocked
    assign rready    = (state == isp_pkg::ST_READ) && wb_space;
    assign beat_take = rvalid && rready;

    // completion flags may arrive in either order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_seen   <= 1'b0;
            mean_seen <= 1'b0;
        end else if (state == isp_pkg::ST_DOUT) begin
            wb_seen   <= 1'b0;
            mean_seen <= 1'b0;
        end else begin
            wb_seen   <= wb_seen | wb_done;
            mean_seen <= mean_seen | mean_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mean_valid) begin
            mean_q <= mean_luma;
        end
    end

    assign out_valid = (state == isp_pkg::ST_DOUT);
    assign out_data  = out_valid ? mean_q : '0;

endmodule

`default_nettype wire

/* hw/isp_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_writeback (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        beat_take,
    input  logic [isp_pkg::DATA_W-1:0]  rdata,
    input  logic                        rlast,
    input  isp_pkg::ratio_e             ratio,
    input  logic                        wready,
    output logic [isp_pkg::DATA_W-1:0]  wdata,
    output logic                        wvalid,
    output logic                        wlast,
    output logic                        wb_space,
    output logic                        wb_done
);

    logic [isp_pkg::DATA_W-1:0] scaled;

    // all lanes of the incoming beat
    always_comb begin
        for (int i = 0; i < isp_pkg::LANES; i++) begin
            scaled[i*isp_pkg::PIXEL_W +: isp_pkg::PIXEL_W] =
                isp_pkg::scale_pixel(rdata[i*isp_pkg::PIXEL_W +: isp_pkg::PIXEL_W], ratio);
        end
    end

    // register is free when empty or emptying this cycle
    assign wb_space = !wvalid || wready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end else if (beat_take) begin
            wvalid <= 1'b1;
            wlast  <= rlast;
        end else if (wready) begin
            wvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            wdata <= scaled;
        end
    end

    assign wb_done = wvalid && wready && wlast;

endmodule

`default_nettype wire

/* hw/isp_luma_sum.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_luma_sum #(
    parameter int BEATS_PER_CHANNEL = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         beat_take,
    input  logic [isp_pkg::DATA_W-1:0]   rdata,
    input  logic                         rlast,
    input  isp_pkg::ratio_e              ratio,
    output logic [isp_pkg::PIXEL_W-1:0]  mean_luma,
    output logic                         mean_valid
);

    localparam int CNT_W = $clog2(BEATS_PER_CHANNEL);
    localparam int SHIFT = $clog2(BEATS_PER_CHANNEL * isp_pkg::LANES);
    localparam int ACC_W = SHIFT + isp_pkg::PIXEL_W;

    logic [CNT_W-1:0]            beat_cnt;
    isp_pkg::chan_e              chan;
    logic                        first_take;
    logic [isp_pkg::PIXEL_W-1:0] scaled [isp_pkg::LANES];
    logic [isp_pkg::PIXEL_W-2:0] weighted [isp_pkg::LANES];
    logic [isp_pkg::PIXEL_W-1:0] sum1 [8];
    logic [isp_pkg::PIXEL_W:0]   sum2 [4];
    logic [isp_pkg::PIXEL_W+1:0] sum3 [2];
    logic [isp_pkg::PIXEL_W+2:0] sum4;
    logic [4:0]                  vld_pipe;
    logic [4:0]                  last_pipe;
    logic [ACC_W-1:0]            acc;

    // ========================================================================
    // channel tracking
    // ========================================================================
    assign first_take = beat_take && (beat_cnt == '0) && (chan == isp_pkg::CH_RED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            chan     <= isp_pkg::CH_RED;
        end else if (beat_take) begin
            if (rlast) begin
                beat_cnt <= '0;
                chan     <= isp_pkg::CH_RED;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
                if (&beat_cnt) begin
                    case (chan)
                        isp_pkg::CH_RED:   chan <= isp_pkg::CH_GREEN;
                        isp_pkg::CH_GREEN: chan <= isp_pkg::CH_BLUE;
                        default:           chan <= isp_pkg::CH_RED;
                    endcase
                end
            end
        end
    end

    // ========================================================================
    // weighting and adder tree
    // ========================================================================
    always_comb begin
        for (int i = 0; i < isp_pkg::LANES; i++) begin
            scaled[i] = isp_pkg::scale_pixel(rdata[i*isp_pkg::PIXEL_W +: isp_pkg::PIXEL_W],
                                             ratio);
        end
    end

    // green counts half, red and blue a quarter each
    always_ff @(posedge clk) begin
        for (int i = 0; i < isp_pkg::LANES; i++) begin
            if (chan == isp_pkg::CH_GREEN) begin
                weighted[i] <= scaled[i][isp_pkg::PIXEL_W-1:1];
            end else begin
                weighted[i] <= {1'b0, scaled[i][isp_pkg::PIXEL_W-1:2]};
            end
        end
        for (int i = 0; i < 8; i++) begin
            sum1[i] <= weighted[2*i] + weighted[2*i+1];
        end
        for (int i = 0; i < 4; i++) begin
            sum2[i] <= sum1[2*i] + sum1[2*i+1];
        end
        for (int i = 0; i < 2; i++) begin
            sum3[i] <= sum2[2*i] + sum2[2*i+1];
        end
        sum4 <= sum3[0] + sum3[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe   <= '0;
            last_pipe  <= '0;
            acc        <= '0;
            mean_valid <= 1'b0;
        end else begin
            vld_pipe   <= {vld_pipe[3:0], beat_take};
            last_pipe  <= {last_pipe[3:0], beat_take && rlast};
            mean_valid <= vld_pipe[4] && last_pipe[4];
            if (first_take) begin
                acc <= '0;
            end else if (vld_pipe[4]) begin
                acc <= acc + sum4;
            end
        end
    end

    // divide by pixels per channel
    assign mean_luma = acc[ACC_W-1:SHIFT];

endmodule

`default_nettype wire

/* hw/isp_top.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_top #(
    parameter int BEATS_PER_CHANNEL = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [3:0]                   in_pic_no,
    input  isp_pkg::ratio_e              in_ratio_mode,
    output logic                         out_valid,
    output logic [isp_pkg::PIXEL_W-1:0]  out_data,
    output logic [isp_pkg::ADDR_W-1:0]   araddr,
    output logic                         arvalid,
    input  logic                         arready,
    output logic [isp_pkg::ADDR_W-1:0]   awaddr,
    output logic                         awvalid,
    input  logic                         awready,
    input  logic [isp_pkg::DATA_W-1:0]   rdata,
    input  logic                         rvalid,
    input  logic                         rlast,
    output logic                         rready,
    output logic [isp_pkg::DATA_W-1:0]   wdata,
    output logic                         wvalid,
    output logic                         wlast,
    input  logic                         wready
);

    isp_pkg::ratio_e             ratio;
    logic                        beat_take;
    logic                        wb_space;
    logic                        wb_done;
    logic [isp_pkg::PIXEL_W-1:0] mean_luma;
    logic                        mean_valid;

    isp_ctrl ctrl_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .ratio         (ratio),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .rvalid        (rvalid),
        .rlast         (rlast),
        .rready        (rready),
        .beat_take     (beat_take),
        .wb_space      (wb_space),
        .wb_done       (wb_done),
        .mean_luma     (mean_luma),
        .mean_valid    (mean_valid),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    // scaled write-back path
    isp_writeback wb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .beat_take (beat_take),
        .rdata     (rdata),
        .rlast     (rlast),
        .ratio     (ratio),
        .wready    (wready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .wb_space  (wb_space),
        .wb_done   (wb_done)
    );

    // brightness statistics
    isp_luma_sum #(
        .BEATS_PER_CHANNEL (BEATS_PER_CHANNEL)
    ) luma_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_take  (beat_take),
        .rdata      (rdata),
        .rlast      (rlast),
        .ratio      (ratio),
        .mean_luma  (mean_luma),
        .mean_valid (mean_valid)
    );

endmodule

`default_nettype wire

/* test/isp_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_asserts (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        arvalid,
    input  logic                        arready,
    input  logic                        awvalid,
    input  logic                        awready,
    input  logic                        rready,
    input  logic [isp_pkg::DATA_W-1:0]  wdata,
    input  logic                        wvalid,
    input  logic                        wlast,
    input  logic                        wready,
    input  logic                        out_valid
);

    int fail_cnt = 0;

    // address valids wait for their ready
    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid)
        else begin
            $error("arvalid dropped before arready");
            fail_cnt++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid)
        else begin
            $error("awvalid dropped before awready");
            fail_cnt++;
        end

    // write register held under back-pressure
    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else begin
            $error("write beat changed while stalled");
            fail_cnt++;
        end

    r_gate: assert property (@(posedge clk) disable iff (!rst_n)
        !(rready && wvalid && !wready))
        else begin
            $error("rready high while the write stage is stalled");
            fail_cnt++;
        end

    out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid high for two cycles");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* test/isp_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module isp_tb;

    localparam int BPC     = 64;
    localparam int BEATS   = 3 * BPC;
    localparam int NREQ    = 8;
    localparam int TIMEOUT = NREQ * (4 * 3 * BPC + 100);

    logic                        clk;
    logic                        rst_n;
    logic                        in_valid;
    logic [3:0]                  in_pic_no;
    isp_pkg::ratio_e             in_ratio_mode;
    logic                        out_valid;
    logic [7:0]                  out_data;
    logic [31:0]                 araddr;
    logic                        arvalid;
    logic                        arready;
    logic [31:0]                 awaddr;
    logic                        awvalid;
    logic                        awready;
    logic [127:0]                rdata;
    logic                        rvalid;
    logic                        rlast;
    logic                        rready;
    logic [127:0]                wdata;
    logic                        wvalid;
    logic                        wlast;
    logic                        wready;

    logic [31:0]                 lfsr;
    logic [127:0]                mem [16*BEATS];
    logic [127:0]                exp_w [BEATS];
    logic [127:0]                wbuf [BEATS];
    int                          exp_mean;
    int                          err_cnt;
    int                          cycle_cnt;
    int                          req_no;
    int                          ar_cnt;
    int                          aw_cnt;
    int                          w_idx;
    int                          out_cnt;
    logic [31:0]                 ar_addr;
    logic [31:0]                 aw_addr;
    logic [7:0]                  out_seen;
    logic                        rd_active;
    int                          rd_idx;
    int                          rd_base;

    isp_top #(
        .BEATS_PER_CHANNEL (BPC)
    ) dut_i (.*);

    bind isp_top isp_asserts asserts_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .awvalid   (awvalid),
        .awready   (awready),
        .rready    (rready),
        .wdata     (wdata),
        .wvalid    (wvalid),
        .wlast     (wlast),
        .wready    (wready),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // random source and reference model
    // ========================================================================
    // fibonacci lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic int scale_ref(input int pix, input int code);
        int res;
        case (code)
            0: res = pix / 4;
            1: res = pix / 2;
            3: res = (pix * 2 > 255) ? 255 : pix * 2;
            default: res = pix;
        endcase
        return res;
    endfunction

    task automatic build_expected(input int pic, input int code);
        logic [127:0] beat;
        int           sum;
        int           s;
        sum = 0;
        for (int k = 0; k < BEATS; k++) begin
            beat = mem[pic * BEATS + k];
            for (int l = 0; l < 16; l++) begin
                s = scale_ref(int'(beat[l*8 +: 8]), code);
                exp_w[k][l*8 +: 8] = s[7:0];
                // green weighs half, red and blue a quarter
                sum += (k / BPC == 1) ? s / 2 : s / 4;
            end
        end
        exp_mean = sum / (BPC * 16);
    endtask

    task automatic value_err(input string item, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
        $display("ERR req%0d %s expected %0h actual %0h", req_no, item, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic check_write();
        if (w_idx >= BEATS) begin
            $display("req%0d: write beat beyond the end of the burst", req_no);
            err_cnt++;
        end else begin
            if (wdata !== exp_w[w_idx]) begin
                value_err($sformatf("wdata beat %0d", w_idx), exp_w[w_idx], wdata);
            end
            if (wlast !== (w_idx == BEATS - 1)) begin
                value_err($sformatf("wlast beat %0d", w_idx), w_idx == BEATS - 1, wlast);
            end
            wbuf[w_idx] = wdata;
        end
        w_idx++;
    endtask

    // ========================================================================
    // DRAM model
    // ========================================================================
    initial begin : dram_model
        logic ar_fire;
        logic aw_fire;
        logic r_fire;
        forever begin
            // sample handshakes mid-cycle
            @(negedge clk);
            ar_fire = arvalid && arready;
            aw_fire = awvalid && awready;
            r_fire  = rvalid && rready;
            if (ar_fire) begin
                ar_cnt++;
                ar_addr = araddr;
            end
            if (aw_fire) begin
                aw_cnt++;
                aw_addr = awaddr;
            end
            if (wvalid && wready) begin
                check_write();
            end
            if (out_valid) begin
                out_cnt++;
                out_seen = out_data;
            end else if (out_data !== 8'h00) begin
                $display("req%0d: out_data is not zero while out_valid is low", req_no);
                err_cnt++;
            end
            @(posedge clk);
            #2;
            if (ar_fire) begin
                rd_active = 1'b1;
                rd_idx    = 0;
                rd_base   = int'((ar_addr - 32'h10000) >> 4);
            end else if (r_fire) begin
                rd_idx++;
                if (rd_idx == BEATS) begin
                    rd_active = 1'b0;
                end
            end
            // a presented beat stays until taken
            if (!(rvalid && !r_fire)) begin
                rvalid = rd_active && (rand_bits(2) != '0);
            end
            if (rd_active) begin
                rdata = mem[(rd_base + rd_idx) % (16 * BEATS)];
            end
            rlast   = rd_active && (rd_idx == BEATS - 1);
            arready = rand_bits(1);
            awready = rand_bits(1);
            wready  = rand_bits(2) != '0;
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: requests still running after %0d cycles", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin : main_seq
        int          pic;
        int          code;
        int          prev_out;
        int          prev_err;
        logic [31:0] exp_addr;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_pic_no     = '0;
        in_ratio_mode = isp_pkg::RATIO_QUARTER;
        arready       = 1'b0;
        awready       = 1'b0;
        rdata         = '0;
        rvalid        = 1'b0;
        rlast         = 1'b0;
        wready        = 1'b0;
        lfsr          = 32'hdd81;
        err_cnt       = 0;
        ar_cnt        = 0;
        aw_cnt        = 0;
        w_idx         = 0;
        out_cnt       = 0;
        rd_active     = 1'b0;
        rd_idx        = 0;
        rd_base       = 0;
        for (int a = 0; a < 16 * BEATS; a++) begin
            mem[a] = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        end
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        prev_err = err_cnt;
        repeat (3) begin
            @(negedge clk);
            if ({out_valid, arvalid, awvalid, rready, wvalid} !== 5'b0) begin
                $display("reset: an output is not low before any request");
                err_cnt++;
            end
        end
        $display("reset state: %s", (err_cnt == prev_err) ? "ok" : "wrong");

        for (req_no = 0; req_no < NREQ; req_no++) begin
            @(posedge clk);
            #1;
            pic  = rand_bits(4);
            code = (req_no < 4) ? req_no : rand_bits(2);
            build_expected(pic, code);
            exp_addr = 32'h10000 + pic * 3072;
            ar_cnt   = 0;
            aw_cnt   = 0;
            w_idx    = 0;
            prev_out = out_cnt;
            prev_err = err_cnt;
            #1;
            in_valid      = 1'b1;
            in_pic_no     = pic[3:0];
            in_ratio_mode = isp_pkg::ratio_e'(code);
            @(posedge clk);
            #2 in_valid = 1'b0;
            while (out_cnt == prev_out) begin
                @(posedge clk);
            end
            // room for a second strobe to show up
            repeat (3) @(posedge clk);
            #1;
            if (out_cnt != prev_out + 1) begin
                $display("req%0d: out_valid came %0d times", req_no, out_cnt - prev_out);
                err_cnt++;
            end
            if (out_seen !== exp_mean[7:0]) begin
                value_err("mean", exp_mean, out_seen);
            end
            if (ar_cnt != 1 || aw_cnt != 1) begin
                $display("req%0d: %0d read and %0d write addresses accepted",
                         req_no, ar_cnt, aw_cnt);
                err_cnt++;
            end
            if (ar_addr !== exp_addr) begin
                value_err("araddr", exp_addr, ar_addr);
            end
            if (aw_addr !== exp_addr) begin
                value_err("awaddr", exp_addr, aw_addr);
            end
            if (w_idx != BEATS) begin
                value_err("write beat count", BEATS, w_idx);
            end
            for (int k = 0; k < BEATS && k < w_idx; k++) begin
                mem[(int'((aw_addr - 32'h10000) >> 4) + k) % (16 * BEATS)] = wbuf[k];
            end
            $display("req %0d pic %0d ratio %0d mean %0d: %s", req_no, pic, code,
                     exp_mean, (err_cnt == prev_err) ? "ok" : "wrong");
        end

        $display("%0d requests, %0d check errors, %0d assertion failures",
                 NREQ, err_cnt, dut_i.asserts_i.fail_cnt);
        if (err_cnt == 0 && dut_i.asserts_i.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/isp_pkg.sv
hw/isp_ctrl.sv
hw/isp_writeback.sv
hw/isp_luma_sum.sv
hw/isp_top.sv
test/isp_asserts.sv
test/isp_tb.sv

/* Bender.yml */
package:
  name: isp_exposure

dependencies: {}

sources:
  # design
  - hw/isp_pkg.sv
  - hw/isp_ctrl.sv
  - hw/isp_writeback.sv
  - hw/isp_luma_sum.sv
  - hw/isp_top.sv

  # testbench
  - target: simulation
    files:
      - test/isp_asserts.sv
      - test/isp_tb.sv
